//--- source/dmx_pkg.sv
`default_nettype none

package dmx_pkg;

	// ########################################
	// csr bus layout.
	// ########################################

	localparam int csr_addr_w = 14;
	localparam int csr_data_w = 32;

	localparam int csr_sel_hi = 13; // block select msb.
	localparam int csr_sel_lo = 10; // block select lsb.
	localparam int csr_ctrl_bit = 9; // 1 picks the control register.

	// one channel slot.
	typedef logic [7:0] dmx_data_t;

	// ########################################
	// line timing.
	// ########################################

	localparam int dmx_baud = 250000;

	// min low time of a received break, roughly 88 us.
	localparam int dmx_break_rx_hz = 11364;

	localparam int dmx_break_tx_bits = 26; // in bit times.

endpackage

`default_nettype wire

//--- source/dmx_dpram.sv
`default_nettype none

module dmx_dpram #(
	parameter int chan_bits = 9
) (
	input  wire                      sys_clk,

	input  wire  [chan_bits-1:0]     a,
	input  wire                      we,
	input  dmx_pkg::dmx_data_t       di,
	output dmx_pkg::dmx_data_t       dout,

	input  wire  [chan_bits-1:0]     a2,
	input  wire                      we2,
	input  dmx_pkg::dmx_data_t       di2,
	output dmx_pkg::dmx_data_t       dout2
);
	import dmx_pkg::*;

	localparam int depth = 1 << chan_bits;

	dmx_data_t mem [0:depth-1];

	// both ports read the old contents on a write.
	always @(posedge sys_clk) begin
		if (we)
			mem[a] <= di;
		dout <= mem[a];
		if (we2)
			mem[a2] <= di2;
		dout2 <= mem[a2];
	end

	initial begin
		for (int i = 0; i < depth; i++)
			mem[i] = '0; // all channels dark.
	end

	// csr side and line side never collide on one slot.
	a_no_dual_write: assert property (@(posedge sys_clk) !(we && we2 && (a == a2)));

endmodule

`default_nettype wire

//--- source/dmx_bit_timer.sv
`default_nettype none

module dmx_bit_timer #(
	parameter int clk_freq = 100000000
) (
	input  wire  sys_clk,
	input  wire  sys_rst,
	input  wire  load,
	output logic ce
);
	import dmx_pkg::*;

	localparam int period = clk_freq / dmx_baud;
	localparam int half = clk_freq / (2 * dmx_baud);
	localparam int cnt_w = $clog2(period + 1);

	logic [cnt_w-1:0] cnt;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			ce <= 1'b0;
			cnt <= cnt_w'(period - 1);
		end else if (load) begin
			ce <= 1'b0;
			cnt <= cnt_w'(half - 1); // first tick lands mid-bit.
		end else if (cnt == '0) begin
			ce <= 1'b1;
			cnt <= cnt_w'(period - 1);
		end else begin
			ce <= 1'b0;
			cnt <= cnt - 1'b1;
		end
	end

	// single cycle tick.
	a_ce_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst) ce |=> !ce);

endmodule

`default_nettype wire

//--- source/dmx_tx.sv
`default_nettype none

module dmx_tx #(
	parameter logic [3:0] csr_addr = 4'h0,
	parameter int clk_freq = 100000000,
	parameter int chan_bits = 9
) (
	input  wire                              sys_clk,
	input  wire                              sys_rst,

	input  wire  [dmx_pkg::csr_addr_w-1:0]   csr_a,
	input  wire                              csr_we,
	input  wire  [dmx_pkg::csr_data_w-1:0]   csr_di,
	output logic [dmx_pkg::csr_data_w-1:0]   csr_do,

	input  wire                              thru,
	output logic                             tx
);
	import dmx_pkg::*;

	// ########################################
	// csr decode and channel ram.
	// ########################################

	logic csr_sel;
	logic ram_we;
	logic thru_en;
	logic ram_rd_r; // last access hit the ram.
	logic ctrl_do_r;
	dmx_data_t csr_dout;
	dmx_data_t seq_dout;
	logic [chan_bits-1:0] acounter;

	assign csr_sel = csr_a[csr_sel_hi:csr_sel_lo] == csr_addr;
	assign ram_we = csr_sel & ~csr_a[csr_ctrl_bit] & csr_we;

	dmx_dpram #(
		.chan_bits(chan_bits)
	) u_ram (
		.sys_clk (sys_clk),
		.a       (csr_a[chan_bits-1:0]),
		.we      (ram_we),
		.di      (csr_di[7:0]),
		.dout    (csr_dout),
		.a2      (acounter),
		.we2     (1'b0), // sequencer only reads.
		.di2     ('0),
		.dout2   (seq_dout)
	);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			thru_en <= 1'b0;
			ram_rd_r <= 1'b0;
			ctrl_do_r <= 1'b0;
		end else begin
			ram_rd_r <= csr_sel & ~csr_a[csr_ctrl_bit];
			ctrl_do_r <= csr_sel & csr_a[csr_ctrl_bit] & thru_en;
			if (csr_sel && csr_a[csr_ctrl_bit] && csr_we)
				thru_en <= csr_di[0];
		end
	end

	assign csr_do = {{(csr_data_w - 8){1'b0}}, ram_rd_r ? csr_dout : {7'd0, ctrl_do_r}};

	// ########################################
	// frame sequencer.
	// ########################################

	typedef enum logic [4:0] {
		st_mtbp, st_break, st_mab1, st_mab2,
		st_sc_start, st_sc_d0, st_sc_d1, st_sc_d2, st_sc_d3,
		st_sc_d4, st_sc_d5, st_sc_d6, st_sc_d7, st_sc_stop1, st_sc_stop2,
		st_start, st_d0, st_d1, st_d2, st_d3,
		st_d4, st_d5, st_d6, st_d7, st_stop1, st_stop2
	} tx_state_t;

	localparam logic [3:0] sel_hi = 4'd8;
	localparam logic [3:0] sel_lo = 4'd9;
	localparam int brk_w = $clog2(dmx_break_tx_bits + 1);

	tx_state_t state, next_state;
	logic bit_ce;
	logic [brk_w-1:0] break_cnt;
	logic break_done;
	logic frame_done;
	logic [3:0] tx_sel; // 0..7 data bit, else fixed level.
	dmx_data_t chan_byte;
	logic tx_gen;

	dmx_bit_timer #(
		.clk_freq(clk_freq)
	) u_timer (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.load    (sys_rst),
		.ce      (bit_ce)
	);

	assign break_done = break_cnt == brk_w'(dmx_break_tx_bits - 1);
	assign frame_done = &acounter;

	always_comb begin
		tx_sel = sel_hi;
		next_state = tx_state_t'(state + 5'd1); // most states just step on.
		case (state)
			st_break: begin
				tx_sel = sel_lo;
				if (!break_done)
					next_state = st_break;
			end
			// zero start code, start bit plus eight low bits.
			st_sc_start, st_sc_d0, st_sc_d1, st_sc_d2, st_sc_d3,
			st_sc_d4, st_sc_d5, st_sc_d6, st_sc_d7, st_start:
				tx_sel = sel_lo;
			st_d0, st_d1, st_d2, st_d3, st_d4, st_d5, st_d6, st_d7:
				tx_sel = {1'b0, 3'(state - st_d0)};
			st_stop2:
				next_state = frame_done ? st_mtbp : st_start;
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= st_mtbp;
		else if (bit_ce)
			state <= next_state;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst || state != st_break)
			break_cnt <= '0;
		else if (bit_ce)
			break_cnt <= break_cnt + 1'b1;
	end

	// channel pointer steps at the end of every slot.
	always_ff @(posedge sys_clk) begin
		if (sys_rst || state == st_mtbp)
			acounter <= '0;
		else if (bit_ce && state == st_stop2)
			acounter <= acounter + 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (bit_ce && state == st_start)
			chan_byte <= seq_dout;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			tx_gen <= 1'b1; // idle mark.
		else if (tx_sel == sel_hi)
			tx_gen <= 1'b1;
		else if (tx_sel == sel_lo)
			tx_gen <= 1'b0;
		else
			tx_gen <= chan_byte[tx_sel[2:0]];
	end

	assign tx = thru_en ? thru : tx_gen;

endmodule

`default_nettype wire

//--- source/dmx_rx.sv
`default_nettype none

module dmx_rx #(
	parameter logic [3:0] csr_addr = 4'h1,
	parameter int clk_freq = 100000000,
	parameter int chan_bits = 9
) (
	input  wire                              sys_clk,
	input  wire                              sys_rst,

	input  wire  [dmx_pkg::csr_addr_w-1:0]   csr_a,
	output logic [dmx_pkg::csr_data_w-1:0]   csr_do,

	input  wire                              rx
);
	import dmx_pkg::*;

	typedef enum logic [2:0] {
		st_wait_break, st_wait_mab, st_wait_start, st_sample_start,
		st_sample_data, st_sample_stop1, st_sample_stop2
	} rx_state_t;

	localparam int brk_cycles = clk_freq / dmx_break_rx_hz;
	localparam int brk_w = $clog2(brk_cycles + 1);

	rx_state_t state, next_state;
	logic rx_meta, rx_s;
	logic [brk_w-1:0] brk_cnt;
	logic break_det;
	logic bit_ce;
	logic load;
	logic shift_en;
	logic byte_ok;
	logic skip; // start code pending.
	logic [2:0] bit_cnt;
	dmx_data_t shreg;
	logic chan_we;
	logic [chan_bits-1:0] chan_a;
	logic csr_sel_r;
	dmx_data_t csr_dout;

	// ########################################
	// line input and break detect.
	// ########################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rx_meta <= 1'b1;
			rx_s <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_s <= rx_meta;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst || rx_s)
			brk_cnt <= brk_w'(brk_cycles);
		else if (!break_det)
			brk_cnt <= brk_cnt - 1'b1;
	end

	assign break_det = brk_cnt == '0;

	// hold the timer until the start edge.
	assign load = state inside {st_wait_break, st_wait_mab, st_wait_start};

	dmx_bit_timer #(
		.clk_freq(clk_freq)
	) u_timer (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.load    (load),
		.ce      (bit_ce)
	);

	// ########################################
	// byte decoder.
	// ########################################

	always_comb begin
		next_state = state;
		shift_en = 1'b0;
		byte_ok = 1'b0;
		case (state)
			st_wait_break: if (break_det) next_state = st_wait_mab;
			st_wait_mab: if (rx_s) next_state = st_wait_start;
			st_wait_start: if (!rx_s) next_state = st_sample_start;
			st_sample_start:
				if (bit_ce)
					next_state = rx_s ? st_wait_break : st_sample_data; // glitch, not a start.
			st_sample_data:
				if (bit_ce) begin
					shift_en = 1'b1;
					if (bit_cnt == 3'd7)
						next_state = st_sample_stop1;
				end
			st_sample_stop1:
				if (bit_ce)
					next_state = rx_s ? st_sample_stop2 : st_wait_break;
			st_sample_stop2:
				if (bit_ce) begin
					if (rx_s) begin
						byte_ok = 1'b1;
						next_state = st_wait_start;
					end else begin
						next_state = st_wait_break;
					end
				end
			default: next_state = st_wait_break;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= st_wait_break;
			bit_cnt <= '0;
			skip <= 1'b1;
			chan_we <= 1'b0;
		end else begin
			state <= next_state;
			if (state != st_sample_data)
				bit_cnt <= '0;
			else if (shift_en)
				bit_cnt <= bit_cnt + 1'b1;
			if (state == st_wait_break)
				skip <= 1'b1;
			else if (byte_ok)
				skip <= 1'b0;
			chan_we <= byte_ok & ~skip; // one cycle after the last stop bit.
		end
	end

	// lsb arrives first.
	always_ff @(posedge sys_clk) begin
		if (shift_en)
			shreg <= {rx_s, shreg[7:1]};
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst || state == st_wait_break || state == st_wait_mab)
			chan_a <= '0;
		else if (chan_we)
			chan_a <= chan_a + 1'b1;
	end

	// ########################################
	// channel ram and csr read.
	// ########################################

	dmx_dpram #(
		.chan_bits(chan_bits)
	) u_ram (
		.sys_clk (sys_clk),
		.a       (csr_a[chan_bits-1:0]),
		.we      (1'b0), // read only from the bus.
		.di      ('0),
		.dout    (csr_dout),
		.a2      (chan_a),
		.we2     (chan_we),
		.di2     (shreg),
		.dout2   ()
	);

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			csr_sel_r <= 1'b0;
		else
			csr_sel_r <= csr_a[csr_sel_hi:csr_sel_lo] == csr_addr;
	end

	assign csr_do = {{(csr_data_w - 8){1'b0}}, csr_sel_r ? csr_dout : 8'h00};

	a_no_write_in_break: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(state == st_wait_break) |-> !chan_we);

endmodule

`default_nettype wire

//--- source/dmx_core.sv
`default_nettype none

module dmx_core #(
	parameter int clk_freq = 100000000,
	parameter int chan_bits = 9,
	parameter logic [3:0] tx_addr = 4'h0,
	parameter logic [3:0] rx_addr = 4'h1
) (
	input  wire                              sys_clk,
	input  wire                              sys_rst,

	input  wire  [dmx_pkg::csr_addr_w-1:0]   csr_a,
	input  wire                              csr_we,
	input  wire  [dmx_pkg::csr_data_w-1:0]   csr_di,
	output logic [dmx_pkg::csr_data_w-1:0]   csr_do,

	input  wire                              thru,
	input  wire                              rx,
	output logic                             tx
);
	import dmx_pkg::*;

	logic [csr_data_w-1:0] tx_csr_do;
	logic [csr_data_w-1:0] rx_csr_do;

	dmx_tx #(
		.csr_addr  (tx_addr),
		.clk_freq  (clk_freq),
		.chan_bits (chan_bits)
	) u_tx (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_a   (csr_a),
		.csr_we  (csr_we),
		.csr_di  (csr_di),
		.csr_do  (tx_csr_do),
		.thru    (thru),
		.tx      (tx)
	);

	dmx_rx #(
		.csr_addr  (rx_addr),
		.clk_freq  (clk_freq),
		.chan_bits (chan_bits)
	) u_rx (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_a   (csr_a),
		.csr_do  (rx_csr_do),
		.rx      (rx)
	);

	// unselected blocks return zero.
	assign csr_do = tx_csr_do | rx_csr_do;

endmodule

`default_nettype wire

//--- verif/dmx_clk_gen.sv
`default_nettype none

module dmx_clk_gen #(
	parameter int half_period = 20,
	parameter int rst_cycles = 8
) (
	output logic sys_clk = 1'b0,
	output logic sys_rst = 1'b1
);

	always #half_period sys_clk = ~sys_clk;

	initial begin
		repeat (rst_cycles) @(posedge sys_clk);
		sys_rst <= 1'b0; // released on a rising edge.
	end

endmodule

`default_nettype wire

//--- verif/dmx_tb.sv
`default_nettype none

module dmx_tb;
	import dmx_pkg::*;

	localparam int clk_freq = 1000000;
	localparam int chan_bits = 4;
	localparam int chan_count = 1 << chan_bits;
	localparam int bit_clks = clk_freq / dmx_baud; // 4 clocks per bit.
	localparam logic [3:0] tx_blk = 4'h0;
	localparam logic [3:0] rx_blk = 4'h1;
	localparam int brk_seen_clks = 80; // longer than any low run inside a slot.
	localparam int thru_hold_clks = (dmx_break_tx_bits + 1) * bit_clks; // longer than the break.
	// frames run about 900 cycles and the loopback needs up to three of them.
	localparam int timeout_cycles = 20000;

	logic sys_clk;
	logic sys_rst;
	logic [csr_addr_w-1:0] csr_a;
	logic csr_we;
	logic [csr_data_w-1:0] csr_di;
	logic [csr_data_w-1:0] csr_do;
	logic thru;
	logic dut_rx;
	logic dut_tx;
	logic loop_en; // 1 feeds tx back into rx.
	logic line_drv;
	integer seed;
	int cycle_cnt = 0;
	dmx_data_t tx_vals [chan_count];

	dmx_clk_gen u_clk (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst)
	);

	dmx_core #(
		.clk_freq  (clk_freq),
		.chan_bits (chan_bits),
		.tx_addr   (tx_blk),
		.rx_addr   (rx_blk)
	) u_dut (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_a   (csr_a),
		.csr_we  (csr_we),
		.csr_di  (csr_di),
		.csr_do  (csr_do),
		.thru    (thru),
		.rx      (dut_rx),
		.tx      (dut_tx)
	);

	assign dut_rx = loop_en ? dut_tx : line_drv;

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_cycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
			$display("Test failed");
			$fatal(1, "run stopped by timeout");
		end
	end

	// ########################################
	// bus and line helpers.
	// ########################################

	function automatic logic [csr_addr_w-1:0] csr_addr_of(input logic [3:0] blk,
		input logic ctrl, input int chan);
		logic [csr_addr_w-1:0] a;
		a = '0;
		a[csr_sel_hi:csr_sel_lo] = blk;
		a[csr_ctrl_bit] = ctrl;
		a[chan_bits-1:0] = chan[chan_bits-1:0];
		return a;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic csr_write(input logic [csr_addr_w-1:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		csr_a <= addr;
		csr_we <= 1'b1;
		csr_di <= data;
		@(posedge sys_clk);
		csr_we <= 1'b0;
	endtask

	// data shows up one cycle after the address.
	task automatic csr_read(input logic [csr_addr_w-1:0] addr, output logic [31:0] data);
		@(posedge sys_clk);
		csr_a <= addr;
		csr_we <= 1'b0;
		@(posedge sys_clk);
		@(negedge sys_clk);
		data = csr_do;
	endtask

	task automatic read_expect(input logic [csr_addr_w-1:0] addr, input logic [31:0] exp,
		input string name);
		logic [31:0] d;
		csr_read(addr, d);
		check_eq(name, d, exp);
	endtask

	task automatic hold_line(input logic lvl, input int nbits);
		line_drv <= lvl;
		repeat (nbits * bit_clks) @(posedge sys_clk);
	endtask

	// 8n2 byte with the lsb first.
	task automatic send_serial_byte(input dmx_data_t value, input logic stop1_lvl);
		hold_line(1'b0, 1);
		for (int i = 0; i < 8; i++)
			hold_line(value[i], 1);
		hold_line(stop1_lvl, 1);
		hold_line(1'b1, 1);
	endtask

	// returns once tx goes high after a long low.
	task automatic wait_break_end();
		int low_cnt;
		low_cnt = 0;
		while (low_cnt < brk_seen_clks) begin
			@(negedge sys_clk);
			if (!dut_tx)
				low_cnt++;
			else
				low_cnt = 0;
		end
		while (!dut_tx)
			@(negedge sys_clk);
	endtask

	// ########################################
	// directed tests.
	// ########################################

	task automatic test_after_reset();
		@(negedge sys_clk);
		check_eq("tx", {31'd0, dut_tx}, 32'd1);
		for (int i = 0; i < chan_count; i++) begin
			read_expect(csr_addr_of(tx_blk, 1'b0, i), 32'd0, $sformatf("csr_do tx ch %0d", i));
			read_expect(csr_addr_of(rx_blk, 1'b0, i), 32'd0, $sformatf("csr_do rx ch %0d", i));
		end
		read_expect(csr_addr_of(tx_blk, 1'b1, 0), 32'd0, "csr_do thru_en");
	endtask

	task automatic test_csr_access();
		logic [31:0] rnd;
		for (int i = 0; i < chan_count; i++) begin
			rnd = $random(seed);
			tx_vals[i] = rnd[7:0];
			csr_write(csr_addr_of(tx_blk, 1'b0, i), {24'd0, tx_vals[i]});
		end
		for (int i = 0; i < chan_count; i++)
			read_expect(csr_addr_of(tx_blk, 1'b0, i), {24'd0, tx_vals[i]},
				$sformatf("csr_do tx ch %0d", i));
		read_expect(csr_addr_of(4'h2, 1'b0, 3), 32'd0, "csr_do block 2");
		// line idle since reset, so rx ram is still dark.
		csr_write(csr_addr_of(rx_blk, 1'b0, 0), 32'h0000_00a5);
		read_expect(csr_addr_of(rx_blk, 1'b0, 0), 32'd0, "csr_do rx ch 0");
	endtask

	task automatic test_loopback();
		@(posedge sys_clk);
		loop_en <= 1'b1;
		wait_break_end();
		wait_break_end(); // one whole frame seen by rx.
		@(posedge sys_clk);
		loop_en <= 1'b0; // cut during the mab so rx stays idle.
		for (int i = 0; i < chan_count; i++)
			read_expect(csr_addr_of(rx_blk, 1'b0, i), {24'd0, tx_vals[i]},
				$sformatf("csr_do rx ch %0d", i));
	endtask

	task automatic test_thru_mode();
		csr_write(csr_addr_of(tx_blk, 1'b1, 0), 32'd1);
		read_expect(csr_addr_of(tx_blk, 1'b1, 0), 32'd1, "csr_do thru_en");
		// each level spans both levels of the frame underneath.
		@(posedge sys_clk);
		thru <= 1'b0;
		repeat (thru_hold_clks) begin
			@(negedge sys_clk);
			check_eq("tx", {31'd0, dut_tx}, 32'd0);
		end
		@(posedge sys_clk);
		thru <= 1'b1;
		repeat (thru_hold_clks) begin
			@(negedge sys_clk);
			check_eq("tx", {31'd0, dut_tx}, 32'd1);
		end
		csr_write(csr_addr_of(tx_blk, 1'b1, 0), 32'd0);
		read_expect(csr_addr_of(tx_blk, 1'b1, 0), 32'd0, "csr_do thru_en");
	endtask

	task automatic test_bad_frame();
		dmx_data_t good0;
		dmx_data_t good1;
		good0 = ~tx_vals[0]; // differs from the loopback value.
		good1 = ~tx_vals[1];
		@(posedge sys_clk);
		hold_line(1'b0, dmx_break_tx_bits);
		hold_line(1'b1, 2);
		send_serial_byte(8'h00, 1'b1);
		send_serial_byte(good0, 1'b1);
		send_serial_byte(good1, 1'b1);
		send_serial_byte(~tx_vals[2], 1'b0); // framing error.
		line_drv <= 1'b1;
		repeat (bit_clks) @(posedge sys_clk);
		read_expect(csr_addr_of(rx_blk, 1'b0, 0), {24'd0, good0}, "csr_do rx ch 0");
		read_expect(csr_addr_of(rx_blk, 1'b0, 1), {24'd0, good1}, "csr_do rx ch 1");
		read_expect(csr_addr_of(rx_blk, 1'b0, 2), {24'd0, tx_vals[2]}, "csr_do rx ch 2");
	endtask

	initial begin
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		thru = 1'b1;
		line_drv = 1'b1;
		loop_en = 1'b0;
		seed = 32'he26b_7fed;
		@(negedge sys_rst);
		test_after_reset();
		test_csr_access();
		test_loopback();
		test_thru_mode();
		test_bad_frame();
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dmx_core.f
source/dmx_pkg.sv
source/dmx_dpram.sv
source/dmx_bit_timer.sv
source/dmx_tx.sv
source/dmx_rx.sv
source/dmx_core.sv
verif/dmx_clk_gen.sv
verif/dmx_tb.sv

//--- run.sh
#!/bin/sh
# Build the DMX512 testbench with Verilator and run it.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
	--top-module dmx_tb \
	-f dmx_core.f \
	--Mdir obj_dir -o dmx_sim; then
	echo "build failed"
	exit 1
fi

sim_out=$(./obj_dir/dmx_sim 2>&1)
sim_rc=$?
printf '%s\n' "$sim_out"

if [ "$sim_rc" -ne 0 ]; then
	echo "simulation exited with status $sim_rc"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
	exit 0
fi

echo "pass line not found in simulation output"
exit 1
